// File: logic/aluCore.sv
`timescale 1ns/1ns

module aluCore
(
	input  logic            clk,
	input  logic            arstN,
	input  logic            exec,
	input  isaPkg::word_t   a,
	input  isaPkg::word_t   b,
	input  isaPkg::opcode_t opcode,
	output isaPkg::word_t   result,
	output statusPkg::psr_t psr
);

	isaPkg::word_t   sum;
	statusPkg::psr_t arithPsr;
	isaPkg::word_t   value;
	statusPkg::psr_t logicPsr;

	// Registered carry back into the adder
	logic carry;

	arithUnit arithUnit_i (
		.a        (a),
		.b        (b),
		.opcode   (opcode),
		.carryIn  (carry),
		.sum      (sum),
		.arithPsr (arithPsr)
	);

	logicShiftUnit logicShiftUnit_i (
		.a        (a),
		.b        (b),
		.opcode   (opcode),
		.value    (value),
		.logicPsr (logicPsr)
	);

	resultMerge resultMerge_i (
		.clk      (clk),
		.arstN    (arstN),
		.exec     (exec),
		.opcode   (opcode),
		.sum      (sum),
		.arithPsr (arithPsr),
		.value    (value),
		.logicPsr (logicPsr),
		.result   (result),
		.psr      (psr),
		.carryOut (carry)
	);

endmodule

// File: logic/arithUnit.sv
`timescale 1ns/1ns

module arithUnit
(
	input  isaPkg::word_t   a,
	input  isaPkg::word_t   b,
	input  isaPkg::opcode_t opcode,
	input  logic            carryIn,
	output isaPkg::word_t   sum,
	output statusPkg::psr_t arithPsr
);

	// Opcode families
	logic signedAdd;
	logic unsignedAdd;
	logic chainAdd;
	logic signedSub;
	logic compare;

	// Datapath
	logic [isaPkg::WORD_WIDTH:0] addWide;
	isaPkg::word_t               addWord;
	isaPkg::word_t               subWord;
	logic                        addOverflow;
	logic                        subOverflow;
	logic                        unsignedLess;
	logic                        signedLess;

	always_comb
	begin
		signedAdd   = (opcode == isaPkg::ADD) || (opcode == isaPkg::ADDI);
		chainAdd    = (opcode == isaPkg::ADDCU) || (opcode == isaPkg::ADDCUI);
		unsignedAdd = (opcode == isaPkg::ADDU) || (opcode == isaPkg::ADDUI) || chainAdd;
		signedSub   = (opcode == isaPkg::SUB) || (opcode == isaPkg::SUBI);
		compare     = (opcode == isaPkg::CMP) || (opcode == isaPkg::CMPI);
	end

	////////////////////////////////////////////////////////////
	// Adder and subtractor
	////////////////////////////////////////////////////////////

	// Carry-in only enters for the chained adds
	assign addWide = {1'b0, a} + {1'b0, b}
		+ {{isaPkg::WORD_WIDTH{1'b0}}, chainAdd & carryIn};
	assign addWord = addWide[isaPkg::WORD_WIDTH-1:0];
	assign subWord = a - b;

	// Same operand signs, different result sign
	assign addOverflow = (a[isaPkg::SIGN_BIT] == b[isaPkg::SIGN_BIT])
		&& (addWord[isaPkg::SIGN_BIT] != a[isaPkg::SIGN_BIT]);

	// Different operand signs, result sign flipped away from A
	assign subOverflow = (a[isaPkg::SIGN_BIT] != b[isaPkg::SIGN_BIT])
		&& (subWord[isaPkg::SIGN_BIT] != a[isaPkg::SIGN_BIT]);

	assign unsignedLess = a < b;
	assign signedLess   = $signed(a) < $signed(b);

	////////////////////////////////////////////////////////////
	// Result and flag candidates
	////////////////////////////////////////////////////////////

	always_comb
	begin
		sum      = '0;
		arithPsr = '0;
		if (signedAdd || unsignedAdd)
		begin
			sum = addWord;
			arithPsr[statusPkg::LOW_BIT]  = unsignedLess;
			arithPsr[statusPkg::ZERO_BIT] = (addWord == '0);
			if (unsignedAdd)
				arithPsr[statusPkg::CARRY_BIT] = addWide[isaPkg::WORD_WIDTH];
			else
			begin
				arithPsr[statusPkg::FLAG_BIT] = addOverflow;
				arithPsr[statusPkg::NEG_BIT]  = addWord[isaPkg::SIGN_BIT];
			end
		end
		else if (signedSub)
		begin
			sum = subWord;
			arithPsr[statusPkg::FLAG_BIT] = subOverflow;
			arithPsr[statusPkg::LOW_BIT]  = unsignedLess;
			arithPsr[statusPkg::NEG_BIT]  = subWord[isaPkg::SIGN_BIT];
			arithPsr[statusPkg::ZERO_BIT] = (subWord == '0);
		end
		else if (compare)
		begin
			// Flags only, the result stays zero
			arithPsr[statusPkg::LOW_BIT]  = unsignedLess;
			arithPsr[statusPkg::NEG_BIT]  = signedLess;
			arithPsr[statusPkg::ZERO_BIT] = (a == b);
		end
	end

endmodule

// File: logic/isaPkg.sv
package isaPkg;

	////////////////////////////////////////////////////////////
	// Word and opcode widths
	////////////////////////////////////////////////////////////

	// Fixed by the instruction set
	localparam int WORD_WIDTH   = 16;
	localparam int OPCODE_WIDTH = 8;
	localparam int SIGN_BIT     = WORD_WIDTH - 1;
	localparam int SHIFT_BITS   = $clog2(WORD_WIDTH);

	typedef logic [WORD_WIDTH-1:0]   word_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;

	////////////////////////////////////////////////////////////
	// Opcode encodings
	////////////////////////////////////////////////////////////

	// Add and subtract families
	localparam opcode_t ADD    = 8'h05;
	localparam opcode_t ADDI   = 8'h50;
	localparam opcode_t ADDU   = 8'h06;
	localparam opcode_t ADDUI  = 8'h60;
	localparam opcode_t ADDCU  = 8'h07;
	localparam opcode_t ADDCUI = 8'h70;
	localparam opcode_t SUB    = 8'h09;
	localparam opcode_t SUBI   = 8'h90;
	localparam opcode_t CMP    = 8'h0B;
	localparam opcode_t CMPI   = 8'hB0;

	// Bitwise family
	localparam opcode_t TEST   = 8'h08;
	localparam opcode_t AND    = 8'h01;
	localparam opcode_t OR     = 8'h02;
	localparam opcode_t XOR    = 8'h03;
	localparam opcode_t NOT    = 8'h0F;

	// Shifts, count taken from the full B word
	localparam opcode_t LSH    = 8'h84;
	localparam opcode_t LSHI   = 8'h80;
	localparam opcode_t RSH    = 8'h8C;
	localparam opcode_t RSHI   = 8'h81;
	localparam opcode_t ALSH   = 8'h86;
	localparam opcode_t ARSH   = 8'h8E;

	localparam opcode_t NOP    = 8'h00;

	// Which unit produces the result
	typedef enum logic [1:0] {
		ARITH,
		LOGIC,
		NONE
	} opClass_t;

endpackage

// File: logic/logicShiftUnit.sv
`timescale 1ns/1ns

module logicShiftUnit
(
	input  isaPkg::word_t   a,
	input  isaPkg::word_t   b,
	input  isaPkg::opcode_t opcode,
	output isaPkg::word_t   value,
	output statusPkg::psr_t logicPsr
);

	// Opcode families, NOT kept apart from the two-operand bitwise ops
	logic bitwise;
	logic invert;
	logic shiftLeft;
	logic shiftRight;
	logic shiftArith;

	isaPkg::word_t                   bitwiseWord;
	logic                            countOver;
	logic [isaPkg::SHIFT_BITS-1:0]   count;
	isaPkg::word_t                   signFill;
	logic [2*isaPkg::WORD_WIDTH-1:0] arithWide;

	always_comb
	begin
		bitwise    = (opcode == isaPkg::AND) || (opcode == isaPkg::TEST)
			|| (opcode == isaPkg::OR) || (opcode == isaPkg::XOR);
		invert     = (opcode == isaPkg::NOT);
		shiftLeft  = (opcode == isaPkg::LSH) || (opcode == isaPkg::LSHI)
			|| (opcode == isaPkg::ALSH);
		shiftRight = (opcode == isaPkg::RSH) || (opcode == isaPkg::RSHI);
		shiftArith = (opcode == isaPkg::ARSH);
	end

	// TEST computes the same word as AND
	always_comb
	begin
		if (opcode == isaPkg::OR)
			bitwiseWord = a | b;
		else if (opcode == isaPkg::XOR)
			bitwiseWord = a ^ b;
		else
			bitwiseWord = a & b;
	end

	// Any count bit above the low four shifts everything out
	assign countOver = |b[isaPkg::WORD_WIDTH-1:isaPkg::SHIFT_BITS];
	assign count     = b[isaPkg::SHIFT_BITS-1:0];
	assign signFill  = {isaPkg::WORD_WIDTH{a[isaPkg::SIGN_BIT]}};

	// Sign copies sit above A and slide down into the low word
	assign arithWide = {signFill, a} >> count;

	always_comb
	begin
		value    = '0;
		logicPsr = '0;
		if (bitwise)
		begin
			value = bitwiseWord;
			logicPsr[statusPkg::LOW_BIT] = a < b;
			logicPsr[statusPkg::NEG_BIT] = $signed(a) < $signed(b);
		end
		else if (invert)
			value = ~a;
		else if (shiftLeft && !countOver)
			value = a << count;
		else if (shiftRight && !countOver)
			value = a >> count;
		else if (shiftArith)
			value = countOver ? signFill : arithWide[isaPkg::WORD_WIDTH-1:0];
		logicPsr[statusPkg::ZERO_BIT] = (bitwise || invert || shiftLeft
			|| shiftRight || shiftArith) && (value == '0);
	end

endmodule

// File: logic/resultMerge.sv
`timescale 1ns/1ns

module resultMerge
(
	input  logic            clk,
	input  logic            arstN,
	input  logic            exec,
	input  isaPkg::opcode_t opcode,
	input  isaPkg::word_t   sum,
	input  statusPkg::psr_t arithPsr,
	input  isaPkg::word_t   value,
	input  statusPkg::psr_t logicPsr,
	output isaPkg::word_t   result,
	output statusPkg::psr_t psr,
	output logic            carryOut
);

	isaPkg::opClass_t opClass;
	isaPkg::word_t    nextResult;
	statusPkg::psr_t  nextPsr;

	////////////////////////////////////////////////////////////
	// Opcode class decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			isaPkg::ADD,
			isaPkg::ADDI,
			isaPkg::ADDU,
			isaPkg::ADDUI,
			isaPkg::ADDCU,
			isaPkg::ADDCUI,
			isaPkg::SUB,
			isaPkg::SUBI,
			isaPkg::CMP,
			isaPkg::CMPI:
				opClass = isaPkg::ARITH;
			isaPkg::TEST,
			isaPkg::AND,
			isaPkg::OR,
			isaPkg::XOR,
			isaPkg::NOT,
			isaPkg::LSH,
			isaPkg::LSHI,
			isaPkg::RSH,
			isaPkg::RSHI,
			isaPkg::ALSH,
			isaPkg::ARSH:
				opClass = isaPkg::LOGIC;
			// NOP lands here with every unknown code
			default:
				opClass = isaPkg::NONE;
		endcase
	end

	always_comb
	begin
		case (opClass)
			isaPkg::ARITH:
			begin
				nextResult = sum;
				nextPsr    = arithPsr;
			end
			isaPkg::LOGIC:
			begin
				nextResult = value;
				nextPsr    = logicPsr;
			end
			default:
			begin
				nextResult = '0;
				nextPsr    = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output registers, loaded on exec
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			result <= '0;
			psr    <= '0;
		end
		else if (exec)
		begin
			result <= nextResult;
			psr    <= nextPsr;
		end
	end

	// Chains into the next ADDCU or ADDCUI
	assign carryOut = psr[statusPkg::CARRY_BIT];

endmodule

// File: logic/statusPkg.sv
package statusPkg;

	////////////////////////////////////////////////////////////
	// Processor status word
	////////////////////////////////////////////////////////////

	localparam int PSR_WIDTH = 5;

	typedef logic [PSR_WIDTH-1:0] psr_t;

	// Unsigned carry-out of the unsigned add family
	localparam int CARRY_BIT = 4;

	// Signed overflow
	localparam int FLAG_BIT  = 3;

	// Unsigned less-than
	localparam int LOW_BIT   = 2;

	// Sign of result, or signed less-than for compares
	localparam int NEG_BIT   = 1;

	localparam int ZERO_BIT  = 0;

endpackage

// File: run.sh
#!/bin/sh
# Build the ALU testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module aluCore_tb -f vlog.f

status=0
./obj_dir/ValuCore_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"

// File: verification/aluCore_assert.sv
`timescale 1ns/1ns

module aluCore_assert
(
	input logic             clk,
	input logic             arstN,
	input logic             exec,
	input isaPkg::opcode_t  opcode,
	input isaPkg::word_t    result,
	input statusPkg::psr_t  psr
);

	logic unsignedAdd;
	logic compare;

	assign unsignedAdd = opcode inside {isaPkg::ADDU, isaPkg::ADDUI,
		isaPkg::ADDCU, isaPkg::ADDCUI};
	assign compare = (opcode == isaPkg::CMP) || (opcode == isaPkg::CMPI);

	////////////////////////////////////////////////////////////
	// Registered status checks
	////////////////////////////////////////////////////////////

	resetClear: assert property (@(posedge clk) !arstN |-> (result == '0) && (psr == '0))
		else $error("result or psr not zero while in reset");

	// Registers only move on exec
	holdStable: assert property (@(posedge clk) disable iff (!arstN)
		!exec |=> $stable(result) && $stable(psr))
		else $error("outputs changed with exec low");

	carryOnlyUnsigned: assert property (@(posedge clk) disable iff (!arstN)
		exec && !unsignedAdd |=> !psr[statusPkg::CARRY_BIT])
		else $error("Carry set after an opcode outside the unsigned add family");

	compareNoResult: assert property (@(posedge clk) disable iff (!arstN)
		exec && compare |=> result == '0)
		else $error("result not zero after a compare");

endmodule

bind resultMerge aluCore_assert aluCore_assert_i (
	.clk     (clk),
	.arstN   (arstN),
	.exec    (exec),
	.opcode  (opcode),
	.result  (result),
	.psr     (psr)
);

// File: verification/aluCore_tb.sv
`timescale 1ns/1ns

module aluCore_tb;

	logic            clk;
	logic            arstN;
	logic            exec;
	isaPkg::word_t   a;
	isaPkg::word_t   b;
	isaPkg::opcode_t opcode;
	isaPkg::word_t   result;
	statusPkg::psr_t psr;

	// Expected outputs, oldest first
	isaPkg::word_t   expResults[$];
	statusPkg::psr_t expPsrs[$];
	isaPkg::word_t   wantResult;
	statusPkg::psr_t wantPsr;
	isaPkg::word_t   lastResult;
	statusPkg::psr_t lastPsr;
	logic            modelCarry;
	logic            issuedLast;
	int              checkCount;
	int              errorCount;
	int              testErrors;

	isaPkg::opcode_t arithOps[10] = '{isaPkg::ADD, isaPkg::ADDI, isaPkg::ADDU,
		isaPkg::ADDUI, isaPkg::ADDCU, isaPkg::ADDCUI, isaPkg::SUB, isaPkg::SUBI,
		isaPkg::CMP, isaPkg::CMPI};
	isaPkg::opcode_t logicOps[11] = '{isaPkg::TEST, isaPkg::AND, isaPkg::OR,
		isaPkg::XOR, isaPkg::NOT, isaPkg::LSH, isaPkg::LSHI, isaPkg::RSH,
		isaPkg::RSHI, isaPkg::ALSH, isaPkg::ARSH};

	aluCore aluCore_i (
		.clk    (clk),
		.arstN  (arstN),
		.exec   (exec),
		.a      (a),
		.b      (b),
		.opcode (opcode),
		.result (result),
		.psr    (psr)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic void aluModel(input isaPkg::opcode_t op, input isaPkg::word_t x,
		input isaPkg::word_t y, input logic carryIn, output isaPkg::word_t res,
		output statusPkg::psr_t flags);
		logic [16:0] wide;
		int          s;
		int          cnt;
		logic        c;
		logic        f;
		logic        l;
		logic        n;
		logic        z;
		res = '0;
		c = 1'b0;
		f = 1'b0;
		l = 1'b0;
		n = 1'b0;
		z = 1'b0;
		case (op)
			isaPkg::ADD, isaPkg::ADDI, isaPkg::SUB, isaPkg::SUBI:
			begin
				// Overflow as the signed sum leaving the 16-bit range
				if (op == isaPkg::ADD || op == isaPkg::ADDI)
					s = int'($signed(x)) + int'($signed(y));
				else
					s = int'($signed(x)) - int'($signed(y));
				res = isaPkg::word_t'(s);
				f = (s > 32767) || (s < -32768);
				l = x < y;
				n = res[15];
				z = (res == 0);
			end
			isaPkg::ADDU, isaPkg::ADDUI, isaPkg::ADDCU, isaPkg::ADDCUI:
			begin
				wide = {1'b0, x} + {1'b0, y};
				if (op == isaPkg::ADDCU || op == isaPkg::ADDCUI)
					wide = wide + 17'(carryIn);
				res = wide[15:0];
				c = wide[16];
				l = x < y;
				z = (res == 0);
			end
			isaPkg::CMP, isaPkg::CMPI:
			begin
				l = x < y;
				n = $signed(x) < $signed(y);
				z = (x == y);
			end
			isaPkg::AND, isaPkg::TEST, isaPkg::OR, isaPkg::XOR:
			begin
				if (op == isaPkg::OR)
					res = x | y;
				else if (op == isaPkg::XOR)
					res = x ^ y;
				else
					res = x & y;
				l = x < y;
				n = $signed(x) < $signed(y);
				z = (res == 0);
			end
			isaPkg::NOT:
			begin
				res = ~x;
				z = (res == 0);
			end
			isaPkg::LSH, isaPkg::LSHI, isaPkg::ALSH, isaPkg::RSH, isaPkg::RSHI:
			begin
				if (y >= 16)
					res = '0;
				else if (op == isaPkg::RSH || op == isaPkg::RSHI)
					res = x >> y[3:0];
				else
					res = x << y[3:0];
				z = (res == 0);
			end
			isaPkg::ARSH:
			begin
				// Shifting by 15 already leaves only sign copies
				cnt = (y > 15) ? 15 : int'(y);
				res = isaPkg::word_t'($signed(x) >>> cnt);
				z = (res == 0);
			end
			default:
				res = '0;
		endcase
		flags = '0;
		flags[statusPkg::CARRY_BIT] = c;
		flags[statusPkg::FLAG_BIT]  = f;
		flags[statusPkg::LOW_BIT]   = l;
		flags[statusPkg::NEG_BIT]   = n;
		flags[statusPkg::ZERO_BIT]  = z;
	endfunction

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	// Was there an issue at the last rising edge
	always @(posedge clk)
		issuedLast <= exec && arstN;

	always @(negedge clk)
	begin
		if (issuedLast)
		begin
			if (expResults.size() == 0)
			begin
				errorCount++;
				$display("DUT produced an output with no expected value queued");
			end
			else
			begin
				wantResult = expResults.pop_front();
				wantPsr    = expPsrs.pop_front();
				checkValue("result", result, wantResult);
				checkValue("psr", 16'(psr), 16'(wantPsr));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Called on a falling edge, returns on the next one
	task automatic issue(input isaPkg::opcode_t op, input isaPkg::word_t x,
		input isaPkg::word_t y);
		isaPkg::word_t   r;
		statusPkg::psr_t p;
		aluModel(op, x, y, modelCarry, r, p);
		expResults.push_back(r);
		expPsrs.push_back(p);
		modelCarry = p[statusPkg::CARRY_BIT];
		lastResult = r;
		lastPsr    = p;
		opcode = op;
		a      = x;
		b      = y;
		exec   = 1'b1;
		@(negedge clk);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		exec = 1'b0;
		while (expResults.size() != 0 && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (expResults.size() != 0)
		begin
			errorCount++;
			$display("Timeout: %0d expected results were never compared", expResults.size());
			expResults.delete();
			expPsrs.delete();
		end
	endtask

	task automatic testDone(input string name);
		$display("Test %s finished with %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]     x;
		logic [31:0]     y;
		logic [32:0]     full;
		isaPkg::opcode_t op;
		void'($urandom(43333));
		clk        = 1'b0;
		arstN      = 1'b0;
		exec       = 1'b0;
		a          = '0;
		b          = '0;
		opcode     = isaPkg::NOP;
		modelCarry = 1'b0;
		issuedLast = 1'b0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;

		repeat (3) @(negedge clk);
		arstN = 1'b1;
		checkValue("result", result, '0);
		checkValue("psr", 16'(psr), '0);
		testDone("reset");

		// Overflow, carry and equality corners first
		issue(isaPkg::ADD, 16'h7FFF, 16'h0001);
		issue(isaPkg::ADDI, 16'h8000, 16'h8000);
		issue(isaPkg::ADDU, 16'hFFFF, 16'h0001);
		issue(isaPkg::ADDCU, 16'hFFFF, 16'h0000);
		issue(isaPkg::SUB, 16'h8000, 16'h0001);
		issue(isaPkg::SUBI, 16'h7FFF, 16'hFFFF);
		issue(isaPkg::CMP, 16'h1234, 16'h1234);
		issue(isaPkg::CMPI, 16'h8000, 16'h0001);
		repeat (200)
			issue(arithOps[$urandom_range(0, 9)], isaPkg::word_t'($urandom()),
				isaPkg::word_t'($urandom()));
		drain();
		testDone("arithmetic");

		// Low word then high word with the chained carry
		for (int i = 0; i < 20; i++)
		begin
			x = (i == 0) ? 32'hFFFF_FFFF : $urandom();
			y = (i == 0) ? 32'h0000_0001 : $urandom();
			full = {1'b0, x} + {1'b0, y};
			issue(isaPkg::ADDU, x[15:0], y[15:0]);
			issue(isaPkg::ADDCU, x[31:16], y[31:16]);
			checkValue("upper result", result, full[31:16]);
			checkValue("carry", 16'(psr[statusPkg::CARRY_BIT]), 16'(full[32]));
		end
		drain();
		testDone("carry chain");

		issue(isaPkg::LSH, 16'hA5A5, 16'd0);
		issue(isaPkg::LSHI, 16'hA5A5, 16'd15);
		issue(isaPkg::RSH, 16'h8000, 16'd15);
		issue(isaPkg::RSHI, 16'hFFFF, 16'd16);
		issue(isaPkg::ALSH, 16'h0001, 16'd17);
		issue(isaPkg::ARSH, 16'h8001, 16'd1);
		issue(isaPkg::ARSH, 16'h8001, 16'd15);
		issue(isaPkg::ARSH, 16'h8001, 16'd16);
		issue(isaPkg::ARSH, 16'h9000, 16'hFFFF);
		issue(isaPkg::NOT, 16'hFFFF, 16'h0000);
		issue(isaPkg::TEST, 16'h00F0, 16'h0F00);
		repeat (200)
		begin
			op = logicOps[$urandom_range(0, 10)];
			// Half the counts stay near the word width
			y = ($urandom_range(0, 1) == 1) ? $urandom() : $urandom_range(0, 20);
			issue(op, isaPkg::word_t'($urandom()), y[15:0]);
		end
		drain();
		testDone("logic and shifts");

		issue(isaPkg::XOR, 16'h1234, 16'h00FF);
		exec   = 1'b0;
		opcode = isaPkg::ADD;
		a      = isaPkg::word_t'($urandom());
		b      = isaPkg::word_t'($urandom());
		repeat (5)
		begin
			@(negedge clk);
			checkValue("held result", result, lastResult);
			checkValue("held psr", 16'(psr), 16'(lastPsr));
		end
		repeat (8)
			issue(($urandom_range(0, 1) == 1) ? arithOps[$urandom_range(0, 9)]
				: logicOps[$urandom_range(0, 10)], isaPkg::word_t'($urandom()),
				isaPkg::word_t'($urandom()));
		drain();
		testDone("hold and issue");

		issue(isaPkg::NOP, isaPkg::word_t'($urandom()), isaPkg::word_t'($urandom()));
		checkValue("NOP result", result, '0);
		checkValue("NOP psr", 16'(psr), '0);
		issue(8'hFF, 16'hFFFF, 16'hFFFF);
		issue(8'h42, 16'h8000, 16'h0001);
		issue(8'hC3, isaPkg::word_t'($urandom()), isaPkg::word_t'($urandom()));
		checkValue("unknown result", result, '0);
		checkValue("unknown psr", 16'(psr), '0);
		drain();
		testDone("NOP and unknown");

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: vlog.f
logic/isaPkg.sv
logic/statusPkg.sv
logic/arithUnit.sv
logic/logicShiftUnit.sv
logic/resultMerge.sv
logic/aluCore.sv
verification/aluCore_assert.sv
verification/aluCore_tb.sv
